//--- Makefile
TOP = cache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f flist.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- flist.f
source/cache_pkg.sv
source/way_if.sv
source/cache_way.sv
source/cache_way_select.sv
source/cache_ctrl.sv
source/cache_top.sv
verif/cache_mem_model.sv
verif/cache_props.sv
verif/cache_tb.sv

//--- source/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic        clk,
    input  logic        rst,

    input  logic        cpu_cyc,
    input  logic        cpu_stb,
    input  logic        cpu_we,
    input  logic [31:0] cpu_adr,
    input  logic [31:0] cpu_dat_w,
    output logic [31:0] cpu_dat_r,
    output logic        cpu_ack,
    output logic        cpu_err,

    output logic        mem_cyc,
    output logic        mem_stb,
    output logic        mem_we,
    output logic [31:0] mem_adr,
    input  logic [31:0] mem_dat_r,
    input  logic        mem_ack,

    way_if.ctrl         w0,
    way_if.ctrl         w1,
    input  logic        any_hit,
    input  logic [31:0] hit_data,
    input  logic        victim,
    output logic        touch
);

    enum logic [1:0] {
        idle,
        lookup,
        refill,
        respond
    } state;

    cache_pkg::cache_addr_u addr;   // Latched request address
    logic                   we_q;
    logic                   fill_now;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            cpu_ack <= 1'b0;
            cpu_err <= 1'b0;
            mem_cyc <= 1'b0;
            mem_stb <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (cpu_cyc && cpu_stb) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (we_q) begin
                        cpu_err <= 1'b1;   // Writes not supported
                        state   <= respond;
                    end else if (any_hit) begin
                        cpu_ack <= 1'b1;
                        state   <= respond;
                    end else begin
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                        state   <= refill;
                    end
                end
                refill: begin
                    if (mem_ack) begin
                        mem_cyc <= 1'b0;
                        mem_stb <= 1'b0;
                        cpu_ack <= 1'b1;
                        state   <= respond;
                    end
                end
                respond: begin
                    // Master samples ack/err here and drops stb
                    cpu_ack <= 1'b0;
                    cpu_err <= 1'b0;
                    state   <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Request payload and read data
    always_ff @(posedge clk) begin
        if (state == idle && cpu_cyc && cpu_stb) begin
            addr.raw <= cpu_adr;
            we_q     <= cpu_we;
        end
        if (state == lookup && !we_q && any_hit) begin
            cpu_dat_r <= hit_data;
        end else if (state == refill && mem_ack) begin
            cpu_dat_r <= mem_dat_r;
        end
    end

    assign fill_now = (state == refill) && mem_ack;

    // LRU moves on a hit in lookup or when the refill word lands
    assign touch = (state == lookup && !we_q && any_hit) || fill_now;

    assign w0.set       = addr.f.set;
    assign w0.tag       = addr.f.tag;
    assign w0.fill      = fill_now && !victim;
    assign w0.fill_data = mem_dat_r;

    assign w1.set       = addr.f.set;
    assign w1.tag       = addr.f.tag;
    assign w1.fill      = fill_now && victim;
    assign w1.fill_data = mem_dat_r;

    assign mem_we  = 1'b0;   // Read-only master
    assign mem_adr = {addr.f.tag, addr.f.set, {cache_pkg::off_w{1'b0}}};

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

    // Address split is 28 bit tag, 2 bit set, 2 bit byte offset
    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int set_count = 4;
    localparam int set_w     = 2;
    localparam int tag_w     = 28;
    localparam int off_w     = addr_w - tag_w - set_w;   // Byte offset is ignored

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [set_w-1:0] set;
        logic [off_w-1:0] offset;
    } cache_addr_fields_t;

    // Same word seen as a raw bus address or as its cache fields
    typedef union packed {
        logic [addr_w-1:0]  raw;
        cache_addr_fields_t f;
    } cache_addr_u;

endpackage

//--- source/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic        clk,
    input  logic        rst,

    // Processor side, Wishbone slave
    input  logic        cpu_cyc,
    input  logic        cpu_stb,
    input  logic        cpu_we,
    input  logic [31:0] cpu_adr,
    input  logic [31:0] cpu_dat_w,
    output logic [31:0] cpu_dat_r,
    output logic        cpu_ack,
    output logic        cpu_err,

    // Memory side, Wishbone master
    output logic        mem_cyc,
    output logic        mem_stb,
    output logic        mem_we,
    output logic [31:0] mem_adr,
    input  logic [31:0] mem_dat_r,
    input  logic        mem_ack
);

    logic        any_hit;
    logic [31:0] hit_data;
    logic        victim;
    logic        touch;

    way_if w0_if ();
    way_if w1_if ();

    cache_way u_way0 (
        .clk  (clk),
        .rst  (rst),
        .port (w0_if.way)
    );

    cache_way u_way1 (
        .clk  (clk),
        .rst  (rst),
        .port (w1_if.way)
    );

    cache_way_select u_sel (
        .clk      (clk),
        .rst      (rst),
        .w0       (w0_if.sel),
        .w1       (w1_if.sel),
        .touch    (touch),
        .any_hit  (any_hit),
        .hit_data (hit_data),
        .victim   (victim)
    );

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .cpu_err   (cpu_err),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack),
        .w0        (w0_if.ctrl),
        .w1        (w1_if.ctrl),
        .any_hit   (any_hit),
        .hit_data  (hit_data),
        .victim    (victim),
        .touch     (touch)
    );

endmodule

//--- source/cache_way.sv
`timescale 1ns/1ps

module cache_way (
    input logic clk,
    input logic rst,
    way_if.way  port
);

    logic [cache_pkg::set_count-1:0] valid;
    logic [cache_pkg::tag_w-1:0]     tags [cache_pkg::set_count];
    logic [cache_pkg::data_w-1:0]    words [cache_pkg::set_count];

    logic                            entry_valid;
    logic [cache_pkg::tag_w-1:0]     entry_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (port.fill) begin
            valid[port.set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.fill) begin
            tags[port.set]  <= port.tag;
            words[port.set] <= port.fill_data;
        end
    end

    // Combinational lookup of the selected set
    always_comb begin
        entry_valid = valid[port.set];
        entry_tag   = tags[port.set];
    end

    assign port.hit  = entry_valid && (entry_tag == port.tag);
    assign port.data = words[port.set];   // Only meaningful when hit

endmodule

//--- source/cache_way_select.sv
`timescale 1ns/1ps

module cache_way_select (
    input  logic        clk,
    input  logic        rst,
    way_if.sel          w0,
    way_if.sel          w1,
    input  logic        touch,
    output logic        any_hit,
    output logic [31:0] hit_data,
    output logic        victim
);

    logic [cache_pkg::set_count-1:0] lru;   // Bit set means way 1 is next victim
    logic                            used_way;

    assign any_hit = w0.hit | w1.hit;

    always_comb begin
        if (w1.hit) begin
            hit_data = w1.data;
        end else begin
            hit_data = w0.data;
        end
    end

    assign victim = lru[w0.set];

    // With no hit the access was a refill, which lands in the victim
    always_comb begin
        if (w1.hit) begin
            used_way = 1'b1;
        end else if (w0.hit) begin
            used_way = 1'b0;
        end else begin
            used_way = victim;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lru <= '0;   // Way 0 is victim everywhere
        end else if (touch) begin
            lru[w0.set] <= ~used_way;   // Other way goes next
        end
    end

endmodule

//--- source/way_if.sv
`timescale 1ns/1ps

interface way_if;

    logic [cache_pkg::set_w-1:0]  set;         // Set index of the current request
    logic [cache_pkg::tag_w-1:0]  tag;         // Tag to compare against
    logic                         fill;        // One cycle write strobe
    logic [cache_pkg::data_w-1:0] fill_data;   // Word from backing memory
    logic                         hit;
    logic [cache_pkg::data_w-1:0] data;

    modport ctrl (
        output set,
        output tag,
        output fill,
        output fill_data,
        input  hit,
        input  data
    );

    modport way (
        input  set,
        input  tag,
        input  fill,
        input  fill_data,
        output hit,
        output data
    );

    modport sel (
        input  set,
        input  hit,
        input  data
    );

endinterface

//--- verif/cache_mem_model.sv
`timescale 1ns/1ps

module cache_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] key,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    output logic [31:0] dat_r,
    output logic        ack
);

    logic [7:0]  lfsr      = 8'd54;
    logic [7:0]  lfsr_a;
    logic [7:0]  lfsr_b;
    logic [1:0]  new_delay;
    logic [1:0]  wait_left = 2'd0;
    logic        busy      = 1'b0;
    logic        ack_q     = 1'b0;
    logic [31:0] data_q    = '0;

    // Taps 8, 6, 5, 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    assign lfsr_a    = lfsr_next(lfsr);
    assign lfsr_b    = lfsr_next(lfsr_a);
    assign new_delay = {lfsr_a[0], lfsr_b[0]};   // One step per bit

    always @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
            busy  <= 1'b0;
        end else if (ack_q) begin
            ack_q <= 1'b0;   // Single cycle ack
            busy  <= 1'b0;
        end else if (cyc && stb && !we) begin
            if (!busy) begin
                busy <= 1'b1;
                lfsr <= lfsr_b;
                if (new_delay == 2'd0) begin
                    ack_q  <= 1'b1;
                    data_q <= {2'b00, adr[31:2]} ^ key;
                end else begin
                    wait_left <= new_delay - 2'd1;
                end
            end else if (wait_left == 2'd0) begin
                ack_q  <= 1'b1;
                data_q <= {2'b00, adr[31:2]} ^ key;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    assign ack   = ack_q;
    assign dat_r = data_q;

endmodule

//--- verif/cache_props.sv
`timescale 1ns/1ps

module cache_props (
    input logic clk,
    input logic rst,
    input logic cpu_stb,
    input logic cpu_ack,
    input logic cpu_err,
    input logic mem_cyc,
    input logic mem_stb,
    input logic mem_we,
    input logic mem_ack
);

    a_cpu_ack_err: assert property (@(posedge clk) disable iff (rst) !(cpu_ack && cpu_err))
        else $error("cpu_ack and cpu_err high in the same cycle");

    a_cpu_ack_stb: assert property (@(posedge clk) disable iff (rst) cpu_ack |-> cpu_stb)
        else $error("cpu_ack high without cpu_stb");

    a_cpu_err_stb: assert property (@(posedge clk) disable iff (rst) cpu_err |-> cpu_stb)
        else $error("cpu_err high without cpu_stb");

    a_mem_ack_stb: assert property (@(posedge clk) disable iff (rst) mem_ack |-> mem_stb)
        else $error("mem_ack high without mem_stb");

    a_mem_stb_cyc: assert property (@(posedge clk) disable iff (rst) mem_stb |-> mem_cyc)
        else $error("mem_stb high without mem_cyc");

    a_mem_no_write: assert property (@(posedge clk) disable iff (rst) !mem_we)
        else $error("mem_we driven high");

endmodule

bind cache_top cache_props u_props (
    .clk     (clk),
    .rst     (rst),
    .cpu_stb (cpu_stb),
    .cpu_ack (cpu_ack),
    .cpu_err (cpu_err),
    .mem_cyc (mem_cyc),
    .mem_stb (mem_stb),
    .mem_we  (mem_we),
    .mem_ack (mem_ack)
);

//--- verif/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    localparam logic [31:0] data_key = 32'h5a3c_96e1;   // Memory word is word address XOR key
    localparam int timeout_cycles = 50;
    localparam int row_count      = 26;

    typedef struct packed {
        logic        rst_first;   // Second reset before this row
        logic        we;
        logic [31:0] adr;
        logic        fetch;       // One memory read expected
    } row_t;

    logic        clk;
    logic        rst;
    logic        cpu_cyc;
    logic        cpu_stb;
    logic        cpu_we;
    logic [31:0] cpu_adr;
    logic [31:0] cpu_dat_w;
    logic [31:0] cpu_dat_r;
    logic        cpu_ack;
    logic        cpu_err;
    logic        mem_cyc;
    logic        mem_stb;
    logic        mem_we;
    logic [31:0] mem_adr;
    logic [31:0] mem_dat_r;
    logic        mem_ack;

    int          mem_txn_count  = 0;
    logic [31:0] last_mem_adr   = '0;
    int          mismatch_count = 0;
    int          timeout_count  = 0;

    // rst_first, we, adr, fetch
    row_t rows [row_count] = '{
        '{1'b0, 1'b0, 32'h0000_1000, 1'b1},   // Cold miss
        '{1'b0, 1'b0, 32'h0000_1000, 1'b0},
        '{1'b0, 1'b0, 32'h0000_1003, 1'b0},   // Byte offset ignored
        '{1'b0, 1'b0, 32'h0000_2004, 1'b1},   // Two tags in set 1
        '{1'b0, 1'b0, 32'h0000_3004, 1'b1},
        '{1'b0, 1'b0, 32'h0000_2004, 1'b0},
        '{1'b0, 1'b0, 32'h0000_3004, 1'b0},
        '{1'b0, 1'b0, 32'h0000_2004, 1'b0},   // 2004 used last
        '{1'b0, 1'b0, 32'h0000_4004, 1'b1},   // Evicts 3004
        '{1'b0, 1'b0, 32'h0000_2004, 1'b0},
        '{1'b0, 1'b0, 32'h0000_3004, 1'b1},   // Evicts 4004
        '{1'b0, 1'b0, 32'h0000_4004, 1'b1},
        '{1'b0, 1'b0, 32'hffff_fffc, 1'b1},
        '{1'b0, 1'b0, 32'habcd_ef0c, 1'b1},
        '{1'b0, 1'b0, 32'hffff_fffc, 1'b0},
        '{1'b0, 1'b1, 32'h0000_5008, 1'b0},   // Write gets err
        '{1'b0, 1'b0, 32'h0000_5008, 1'b1},
        '{1'b0, 1'b1, 32'h0000_1000, 1'b0},
        '{1'b0, 1'b0, 32'h0000_1000, 1'b0},
        '{1'b1, 1'b0, 32'h0000_1000, 1'b1},   // All cold again
        '{1'b0, 1'b0, 32'h0000_3004, 1'b1},
        '{1'b0, 1'b0, 32'h0000_4004, 1'b1},
        '{1'b0, 1'b0, 32'h0000_5008, 1'b1},
        '{1'b0, 1'b0, 32'hffff_fffc, 1'b1},
        '{1'b0, 1'b0, 32'habcd_ef0c, 1'b1},
        '{1'b0, 1'b0, 32'h0000_1000, 1'b0}
    };

    cache_top uut (
        .clk       (clk),
        .rst       (rst),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .cpu_err   (cpu_err),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    cache_mem_model u_mem (
        .clk   (clk),
        .rst   (rst),
        .key   (data_key),
        .cyc   (mem_cyc),
        .stb   (mem_stb),
        .we    (mem_we),
        .adr   (mem_adr),
        .dat_r (mem_dat_r),
        .ack   (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (mem_cyc && mem_stb && mem_ack) begin
            mem_txn_count <= mem_txn_count + 1;
            last_mem_adr  <= mem_adr;
        end
    end

    function automatic logic [31:0] expected_word(input logic [31:0] adr);
        return {2'b00, adr[31:2]} ^ data_key;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    endtask

    // Holds the request until ack or err is sampled, or the timeout runs out
    task automatic run_request(
        input  logic        we,
        input  logic [31:0] adr,
        output logic [31:0] data,
        output logic        got_ack,
        output logic        got_err,
        output int          cycles
    );
        @(posedge clk);
        cpu_cyc   <= 1'b1;
        cpu_stb   <= 1'b1;
        cpu_we    <= we;
        cpu_adr   <= adr;
        cpu_dat_w <= ~adr;
        cycles  = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        while (!got_ack && !got_err && cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
            got_ack = cpu_ack;
            got_err = cpu_err;
        end
        data = cpu_dat_r;
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        cpu_we  <= 1'b0;
    endtask

    initial begin
        int          txn_before;
        int          want_txn;
        int          cycles;
        logic [31:0] data;
        logic        got_ack;
        logic        got_err;

        rst       = 1'b1;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < row_count; i++) begin
            if (rows[i].rst_first) begin
                apply_reset();
                assert (!cpu_ack && !cpu_err && !mem_cyc && !mem_stb) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: bus outputs active after reset", $time);
                end
            end
            txn_before = mem_txn_count;
            want_txn   = rows[i].fetch ? 1 : 0;
            run_request(rows[i].we, rows[i].adr, data, got_ack, got_err, cycles);
            if (!got_ack && !got_err) begin
                timeout_count++;
                $display("Cache did not answer row %0d, address %h, within %0d cycles",
                         i, rows[i].adr, timeout_cycles);
                break;
            end
            if (rows[i].we) begin
                assert (got_err && !got_ack) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: row %0d write got ack=%b err=%b",
                             $time, i, got_ack, got_err);
                end
            end else begin
                assert (got_ack && !got_err) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: row %0d read got ack=%b err=%b",
                             $time, i, got_ack, got_err);
                end
                assert (data == expected_word(rows[i].adr)) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: row %0d data %h, expected %h",
                             $time, i, data, expected_word(rows[i].adr));
                end
            end
            // Sampled at the drive edge, answered 2 cycles after the cache samples
            if (!rows[i].fetch) begin
                assert (cycles == 3) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: row %0d answered after %0d cycles, expected 3",
                             $time, i, cycles);
                end
            end
            assert (mem_txn_count - txn_before == want_txn) else begin
                mismatch_count++;
                $display("Mismatch at %0t: row %0d made %0d memory reads, expected %0d",
                         $time, i, mem_txn_count - txn_before, want_txn);
            end
            if (rows[i].fetch) begin
                assert (last_mem_adr == {rows[i].adr[31:2], 2'b00}) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: row %0d memory address %h, expected %h",
                             $time, i, last_mem_adr, {rows[i].adr[31:2], 2'b00});
                end
            end
        end

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
